//--- common/vchess_pkg.sv
package vchess_pkg;

   localparam int PIECE_WIDTH      = 4;
   localparam int SIDE_WIDTH       = 32;
   localparam int BOARD_WIDTH      = 256;
   localparam int HALF_MOVE_WIDTH  = 8;
   localparam int MOVE_INDEX_WIDTH = 6;
   localparam int POP_WIDTH        = 7;
   localparam int REG_ADDR_WIDTH   = 10; // Byte address bits 11:2
   localparam int NUM_SQUARES      = BOARD_WIDTH / PIECE_WIDTH;
   localparam int NUM_ROWS         = BOARD_WIDTH / SIDE_WIDTH;

   localparam logic [1:0] RESP_OKAY = 2'b00;

   // Register word addresses
   localparam logic [REG_ADDR_WIDTH-1:0] ADDR_CTRL       = 10'd0;
   localparam logic [REG_ADDR_WIDTH-1:0] ADDR_MOVE_INDEX = 10'd1;
   localparam logic [REG_ADDR_WIDTH-1:0] ADDR_SIDE       = 10'd2;
   localparam logic [REG_ADDR_WIDTH-1:0] ADDR_HALF_MOVE  = 10'd3;
   localparam logic [REG_ADDR_WIDTH-1:0] ADDR_BOARD_BASE = 10'd8; // Rows at 8..15
   localparam logic [REG_ADDR_WIDTH-1:0] ADDR_BOARD_LAST = 10'd15;
   localparam logic [REG_ADDR_WIDTH-1:0] ADDR_POP        = 10'd140;
   localparam logic [REG_ADDR_WIDTH-1:0] ADDR_MISC       = 10'd255;

   typedef enum logic [2:0]
   {
      OP_NONE,
      OP_CTRL,
      OP_MOVE_INDEX,
      OP_SIDE,
      OP_HALF_MOVE,
      OP_BOARD_ROW
   } reg_op_t;

   typedef struct packed
   {
      logic                      valid;
      logic [REG_ADDR_WIDTH-1:0] addr;
      logic [31:0]               data;
   } wr_req_t;

   // CTRL bits 31, 30, 1, 0
   typedef struct packed
   {
      logic soft_reset;
      logic use_random_bit;
      logic clear_moves;
      logic new_board_valid;
   } ctrl_flags_t;

   typedef struct packed
   {
      logic [BOARD_WIDTH-1:0]     board;
      logic                       white_to_move;
      logic [3:0]                 castle_mask;
      logic [3:0]                 ep_col;
      logic [HALF_MOVE_WIDTH-1:0] half_move;
   } position_t;

endpackage

//--- compile.f
common/vchess_pkg.sv
design/ctrl_axi_write.sv
ctrl_regs/ctrl_reg_decode.sv
ctrl_regs/ctrl_reg_file.sv
ctrl_regs/ctrl_read_mux.sv
design/board_pop_count.sv
design/chess_ctrl_top.sv
tb/chess_ctrl_asserts.sv
tb/tb_chess_ctrl.sv

//--- ctrl_regs/ctrl_read_mux.sv
module ctrl_read_mux
(
   input  logic                                    clk,
   input  logic                                    rst,

   input  logic [39:0]                             araddr,
   input  logic [2:0]                              arprot,
   input  logic                                    arvalid,
   input  logic                                    rready,

   input  vchess_pkg::position_t                   pos,
   input  vchess_pkg::ctrl_flags_t                 flags,
   input  logic [vchess_pkg::MOVE_INDEX_WIDTH-1:0] move_index,
   input  logic [vchess_pkg::POP_WIDTH-1:0]        white_pop,
   input  logic [vchess_pkg::POP_WIDTH-1:0]        black_pop,
   input  logic [31:0]                             misc_status,

   output logic                                    arready,
   output logic [31:0]                             rdata,
   output logic [1:0]                              rresp,
   output logic                                    rvalid
);

   logic [vchess_pkg::REG_ADDR_WIDTH-1:0] rd_addr;
   logic [31:0]                           rd_word;

   assign arready = 1'b1; // Always ready
   assign rresp   = vchess_pkg::RESP_OKAY;
   assign rd_addr = araddr[vchess_pkg::REG_ADDR_WIDTH+1:2];

   always_comb
   begin
      rd_word = '0;
      case (rd_addr) inside
         vchess_pkg::ADDR_CTRL:
            rd_word = {flags.soft_reset, flags.use_random_bit, 28'd0,
                       flags.clear_moves, flags.new_board_valid};
         vchess_pkg::ADDR_MOVE_INDEX: rd_word = {26'd0, move_index};
         vchess_pkg::ADDR_SIDE:
            rd_word = {23'd0, pos.white_to_move, pos.castle_mask, pos.ep_col};
         vchess_pkg::ADDR_HALF_MOVE:  rd_word = {24'd0, pos.half_move};
         [vchess_pkg::ADDR_BOARD_BASE:vchess_pkg::ADDR_BOARD_LAST]:
            rd_word = pos.board[rd_addr[2:0]*vchess_pkg::SIDE_WIDTH +: vchess_pkg::SIDE_WIDTH];
         vchess_pkg::ADDR_POP:        rd_word = {18'd0, black_pop, white_pop};
         vchess_pkg::ADDR_MISC:       rd_word = misc_status;
         default:                     rd_word = '0; // Unmapped
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rdata  <= '0;
         rvalid <= 1'b0;
      end
      else if (arvalid)
      begin
         rdata  <= rd_word;
         rvalid <= 1'b1;
      end
      else if (rready)
      begin
         rvalid <= 1'b0;
      end
   end

endmodule

//--- ctrl_regs/ctrl_reg_decode.sv
module ctrl_reg_decode
(
   input  vchess_pkg::wr_req_t wr_req,

   output vchess_pkg::reg_op_t op,
   output logic [2:0]          row
);

   always_comb
   begin
      op  = vchess_pkg::OP_NONE;
      row = wr_req.addr[2:0]; // Only meaningful for board rows
      if (wr_req.valid)
      begin
         case (wr_req.addr) inside
            vchess_pkg::ADDR_CTRL:
            begin
               op = vchess_pkg::OP_CTRL;
            end
            vchess_pkg::ADDR_MOVE_INDEX:
            begin
               op = vchess_pkg::OP_MOVE_INDEX;
            end
            vchess_pkg::ADDR_SIDE:
            begin
               op = vchess_pkg::OP_SIDE;
            end
            vchess_pkg::ADDR_HALF_MOVE:
            begin
               op = vchess_pkg::OP_HALF_MOVE;
            end
            [vchess_pkg::ADDR_BOARD_BASE:vchess_pkg::ADDR_BOARD_LAST]:
            begin
               op = vchess_pkg::OP_BOARD_ROW;
            end
            default:
            begin
               op = vchess_pkg::OP_NONE; // Unmapped, still acknowledged
            end
         endcase
      end
   end

endmodule

//--- ctrl_regs/ctrl_reg_file.sv
module ctrl_reg_file
(
   input  logic                                    clk,
   input  logic                                    rst,

   input  vchess_pkg::wr_req_t                     wr_req,
   input  vchess_pkg::reg_op_t                     op,
   input  logic [2:0]                              row,

   output vchess_pkg::position_t                   pos,
   output vchess_pkg::ctrl_flags_t                 flags,
   output logic [vchess_pkg::MOVE_INDEX_WIDTH-1:0] move_index
);

   logic [31:0] wdata;

   assign wdata = wr_req.data;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pos        <= '0;
         flags      <= '0;
         move_index <= '0;
      end
      else if (wr_req.valid)
      begin
         case (op)
            vchess_pkg::OP_CTRL:
            begin
               flags.new_board_valid <= wdata[0];
               flags.clear_moves     <= wdata[1];
               flags.use_random_bit  <= wdata[30];
               flags.soft_reset      <= wdata[31];
            end
            vchess_pkg::OP_MOVE_INDEX:
            begin
               move_index <= wdata[vchess_pkg::MOVE_INDEX_WIDTH-1:0];
            end
            vchess_pkg::OP_SIDE:
            begin
               pos.white_to_move <= wdata[8];
               pos.castle_mask   <= wdata[7:4];
               pos.ep_col        <= wdata[3:0];
            end
            vchess_pkg::OP_HALF_MOVE:
            begin
               pos.half_move <= wdata[vchess_pkg::HALF_MOVE_WIDTH-1:0];
            end
            vchess_pkg::OP_BOARD_ROW:
            begin
               // One rank of eight squares
               pos.board[row*vchess_pkg::SIDE_WIDTH +: vchess_pkg::SIDE_WIDTH] <=
                  wdata[vchess_pkg::SIDE_WIDTH-1:0];
            end
            default:
            begin
            end
         endcase
      end
   end

endmodule

//--- design/board_pop_count.sv
module board_pop_count
(
   input  logic                                clk,
   input  logic                                rst,
   input  logic [vchess_pkg::BOARD_WIDTH-1:0]  board,
   output logic [vchess_pkg::POP_WIDTH-1:0]    white_pop,
   output logic [vchess_pkg::POP_WIDTH-1:0]    black_pop
);

   logic [vchess_pkg::POP_WIDTH-1:0] white_cnt;
   logic [vchess_pkg::POP_WIDTH-1:0] black_cnt;

   always_comb
   begin
      logic [vchess_pkg::PIECE_WIDTH-1:0] piece;
      white_cnt = '0;
      black_cnt = '0;
      for (int i = 0; i < vchess_pkg::NUM_SQUARES; i++)
      begin
         piece = board[i*vchess_pkg::PIECE_WIDTH +: vchess_pkg::PIECE_WIDTH];
         if (piece != '0)
         begin
            if (piece[vchess_pkg::PIECE_WIDTH-1]) // Colour bit
               black_cnt = black_cnt + 7'd1;
            else
               white_cnt = white_cnt + 7'd1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         white_pop <= '0;
         black_pop <= '0;
      end
      else
      begin
         white_pop <= white_cnt;
         black_pop <= black_cnt;
      end
   end

endmodule

//--- design/chess_ctrl_top.sv
module chess_ctrl_top
(
   input  logic                                    clk,
   input  logic                                    rst,

   input  logic [39:0]                             awaddr,
   input  logic [2:0]                              awprot,
   input  logic                                    awvalid,
   input  logic [31:0]                             wdata,
   input  logic [3:0]                              wstrb,
   input  logic                                    wvalid,
   input  logic                                    bready,
   output logic                                    awready,
   output logic                                    wready,
   output logic [1:0]                              bresp,
   output logic                                    bvalid,

   input  logic [39:0]                             araddr,
   input  logic [2:0]                              arprot,
   input  logic                                    arvalid,
   input  logic                                    rready,
   output logic                                    arready,
   output logic [31:0]                             rdata,
   output logic [1:0]                              rresp,
   output logic                                    rvalid,

   input  logic [31:0]                             misc_status,

   output vchess_pkg::position_t                   pos,
   output vchess_pkg::ctrl_flags_t                 flags,
   output logic [vchess_pkg::MOVE_INDEX_WIDTH-1:0] move_index
);

   vchess_pkg::wr_req_t              wr_req;
   vchess_pkg::reg_op_t              op;
   logic [2:0]                       row;
   logic [vchess_pkg::POP_WIDTH-1:0] white_pop;
   logic [vchess_pkg::POP_WIDTH-1:0] black_pop;

   ctrl_axi_write i_ctrl_axi_write
   (
      .clk     (clk),     .rst    (rst),
      .awaddr  (awaddr),  .awprot (awprot), .awvalid (awvalid),
      .wdata   (wdata),   .wstrb  (wstrb),  .wvalid  (wvalid),
      .bready  (bready),  .awready(awready), .wready (wready),
      .bresp   (bresp),   .bvalid (bvalid), .wr_req  (wr_req)
   );

   ctrl_reg_decode i_ctrl_reg_decode
   (
      .wr_req (wr_req), .op (op), .row (row)
   );

   ctrl_reg_file i_ctrl_reg_file
   (
      .clk (clk), .rst (rst), .wr_req (wr_req), .op (op), .row (row),
      .pos (pos), .flags (flags), .move_index (move_index)
   );

   board_pop_count i_board_pop_count
   (
      .clk (clk), .rst (rst), .board (pos.board),
      .white_pop (white_pop), .black_pop (black_pop)
   );

   ctrl_read_mux i_ctrl_read_mux
   (
      .clk (clk), .rst (rst), .araddr (araddr), .arprot (arprot),
      .arvalid (arvalid), .rready (rready), .pos (pos), .flags (flags),
      .move_index (move_index), .white_pop (white_pop), .black_pop (black_pop),
      .misc_status (misc_status), .arready (arready), .rdata (rdata),
      .rresp (rresp), .rvalid (rvalid)
   );

endmodule

//--- design/ctrl_axi_write.sv
module ctrl_axi_write
(
   input  logic                 clk,
   input  logic                 rst,

   input  logic [39:0]          awaddr,
   input  logic [2:0]           awprot,
   input  logic                 awvalid,
   input  logic [31:0]          wdata,
   input  logic [3:0]           wstrb,
   input  logic                 wvalid,
   input  logic                 bready,

   output logic                 awready,
   output logic                 wready,
   output logic [1:0]           bresp,
   output logic                 bvalid,

   output vchess_pkg::wr_req_t  wr_req
);

   logic accept;

   // Address and data taken together, blocked while a response is pending
   assign accept  = awvalid && wvalid && !bvalid;
   assign awready = accept;
   assign wready  = accept;
   assign bresp   = vchess_pkg::RESP_OKAY;

   assign wr_req.valid = accept;
   assign wr_req.addr  = awaddr[vchess_pkg::REG_ADDR_WIDTH+1:2]; // Word address
   assign wr_req.data  = wdata;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         bvalid <= 1'b0;
      end
      else if (accept)
      begin
         bvalid <= 1'b1;
      end
      else if (bready)
      begin
         bvalid <= 1'b0; // Held until host takes it
      end
   end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the chess control testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --top-module tb_chess_ctrl -f compile.f -o sim_chess_ctrl
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_chess_ctrl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- tb/chess_ctrl_asserts.sv
module chess_ctrl_asserts
(
   input logic clk,
   input logic rst,
   input logic awready,
   input logic wready,
   input logic bvalid,
   input logic bready,
   input logic arvalid,
   input logic rvalid
);

   // Response held until the host takes it
   bvalid_hold: assert property (@(posedge clk) disable iff (rst)
      bvalid && !bready |=> bvalid)
      else $error("bvalid dropped before bready");

   aw_w_ready_equal: assert property (@(posedge clk) awready == wready)
      else $error("awready and wready differ");

   rvalid_after_ar: assert property (@(posedge clk) disable iff (rst)
      arvalid |=> rvalid)
      else $error("rvalid missing the cycle after arvalid");

endmodule

bind chess_ctrl_top chess_ctrl_asserts i_chess_ctrl_asserts
(
   .clk (clk), .rst (rst), .awready (awready), .wready (wready),
   .bvalid (bvalid), .bready (bready), .arvalid (arvalid), .rvalid (rvalid)
);

//--- tb/chess_ctrl_golden.txt
# Columns: op word_addr(hex) value(hex) test_name
# M sets misc_status, W writes, R reads and expects, O expects a DUT output field
M 000 5a5a1234 misc_init
O 000 00000000 rst_flags
O 002 00000000 rst_side_out
O 00b 00000000 rst_board_row3
R 000 00000000 rst_ctrl
R 002 00000000 rst_side
R 00b 00000000 rst_row3
R 08c 00000000 rst_pop
W 000 ffffffff ctrl_all
R 000 c0000003 ctrl_all_rd
W 000 80000001 ctrl_mix
R 000 80000001 ctrl_mix_rd
O 000 00000009 ctrl_mix_out
W 001 ffffffc5 move_index
R 001 00000005 move_index_rd
O 001 00000005 move_index_out
W 002 fffff1a7 side
R 002 000001a7 side_rd
O 002 000001a7 side_out
W 003 12345699 half_move
R 003 00000099 half_move_rd
O 003 00000099 half_move_out
W 008 42365324 row0
W 009 11111111 row1
W 00a 00100000 row2
W 00b 00009000 row3
W 00c 80000000 row4
W 00d 00000000 row5
W 00e 99999999 row6
W 00f cabdebac row7
R 008 42365324 row0_rd
R 009 11111111 row1_rd
R 00a 00100000 row2_rd
R 00b 00009000 row3_rd
R 00c 80000000 row4_rd
R 00d 00000000 row5_rd
R 00e 99999999 row6_rd
R 00f cabdebac row7_rd
O 008 42365324 row0_out
O 00f cabdebac row7_out
R 08c 00000911 pop_load
W 009 0000f000 row1_rewrite
O 009 0000f000 row1_rewrite_out
R 08c 00000989 pop_rewrite
R 0ff 5a5a1234 misc_rd
R 004 00000000 unmapped_rd_4
R 3ff 00000000 unmapped_rd_3ff
W 007 ffffffff unmapped_wr_7
W 08c ffffffff pop_wr_ignored
R 000 80000001 keep_ctrl
R 002 000001a7 keep_side
R 009 0000f000 keep_row1
R 08c 00000989 keep_pop
W 003 00000011 stall_hm_a
W 003 00000022 stall_hm_b
W 003 000000f3 stall_hm_c
R 003 000000f3 stall_hm_rd
O 003 000000f3 stall_hm_out

//--- tb/tb_chess_ctrl.sv
module tb_chess_ctrl;

   localparam string GOLDEN_FILE = "tb/chess_ctrl_golden.txt";

   logic        clk;
   logic        rst;
   logic [39:0] awaddr;
   logic [2:0]  awprot;
   logic        awvalid;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        wvalid;
   logic        bready;
   logic        awready;
   logic        wready;
   logic [1:0]  bresp;
   logic        bvalid;
   logic [39:0] araddr;
   logic [2:0]  arprot;
   logic        arvalid;
   logic        rready;
   logic        arready;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        rvalid;
   logic [31:0] misc_status;

   vchess_pkg::position_t                   pos;
   vchess_pkg::ctrl_flags_t                 flags;
   logic [vchess_pkg::MOVE_INDEX_WIDTH-1:0] move_index;

   byte         step_op[$];
   logic [31:0] step_addr[$];
   logic [31:0] step_value[$];
   string       step_name[$];
   logic [15:0] lfsr;
   int          cycle_count = 0;
   int          cycle_limit = 0;

   chess_ctrl_top i_chess_ctrl_top
   (
      .clk (clk), .rst (rst),
      .awaddr (awaddr), .awprot (awprot), .awvalid (awvalid),
      .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .bready (bready),
      .awready (awready), .wready (wready), .bresp (bresp), .bvalid (bvalid),
      .araddr (araddr), .arprot (arprot), .arvalid (arvalid), .rready (rready),
      .arready (arready), .rdata (rdata), .rresp (rresp), .rvalid (rvalid),
      .misc_status (misc_status), .pos (pos), .flags (flags), .move_index (move_index)
   );

   always #2 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit)
      begin
         $display("Timeout, the DUT did not finish within %0d cycles", cycle_limit);
         $display("Regression failed");
         $fatal(1, "Simulation timed out");
      end
   end

   // 16-bit Galois LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] state);
      logic [15:0] next;
      next = state >> 1;
      if (state[0])
         next = next ^ 16'hB400;
      return next;
   endfunction

   task automatic take_random_bit(output logic bit_out);
      bit_out = lfsr[0];
      lfsr    = lfsr_next(lfsr);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual)
      begin
         $display("[ERROR] %s expected %08h actual %08h", name, expected, actual);
         $display("Regression failed");
         $fatal(1, "Mismatch in %s", name);
      end
   endtask

   function automatic bit step_is_valid(input byte op, input logic [31:0] addr);
      if (op == "M" || op == "W" || op == "R")
         return addr < 32'd1024;
      if (op == "O")
         return addr < 32'd4 || (addr >= 32'd8 && addr < 32'd16); // Output field selector
      return 1'b0;
   endfunction

   task automatic load_golden();
      int          fd;
      int          n;
      string       line;
      string       op_str;
      string       name;
      string       problem;
      logic [31:0] addr;
      logic [31:0] value;
      problem = "";
      fd = $fopen(GOLDEN_FILE, "r");
      if (fd == 0)
         problem = "the golden file could not be opened";
      else
      begin
         while (!$feof(fd) && problem == "")
         begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#")
            begin
               n = $sscanf(line, "%s %h %h %s", op_str, addr, value, name);
               if (n != 4 || !step_is_valid(op_str.getc(0), addr))
                  problem = {"a golden line is malformed: ", line};
               else
               begin
                  step_op.push_back(op_str.getc(0));
                  step_addr.push_back(addr);
                  step_value.push_back(value);
                  step_name.push_back(name);
               end
            end
         end
         $fclose(fd);
      end
      if (problem == "" && step_op.size() == 0)
         problem = "the golden file holds no steps";
      if (problem != "")
      begin
         $display("Cannot run, %s", problem);
         $display("Regression failed");
         $fatal(1, "Golden file unusable");
      end
   endtask

   task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                            input string name);
      logic ready_bit;
      logic done;
      @(posedge clk);
      awaddr  <= {28'd0, addr[9:0], 2'b00};
      wdata   <= data;
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      @(negedge clk);
      while (!awready)
         @(negedge clk);
      check_value({name, "_wready"}, 32'd1, {31'd0, wready});
      @(posedge clk); // Accepted at this edge
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      @(negedge clk);
      check_value({name, "_bvalid"}, 32'd1, {31'd0, bvalid});
      check_value({name, "_bresp"}, 32'd0, {30'd0, bresp});
      done = 1'b0;
      while (!done)
      begin
         take_random_bit(ready_bit);
         @(posedge clk);
         bready <= ready_bit;
         @(negedge clk);
         done = bvalid && bready;
      end
      @(posedge clk);
      bready <= 1'b0;
      @(negedge clk);
      check_value({name, "_single_resp"}, 32'd0, {31'd0, bvalid});
   endtask

   task automatic axi_read(input logic [31:0] addr, input logic [31:0] expected,
                           input string name);
      logic ready_bit;
      logic done;
      @(posedge clk);
      araddr  <= {28'd0, addr[9:0], 2'b00};
      arvalid <= 1'b1;
      @(negedge clk);
      check_value({name, "_arready"}, 32'd1, {31'd0, arready});
      @(posedge clk);
      arvalid <= 1'b0;
      @(negedge clk);
      while (!rvalid)
         @(negedge clk);
      check_value(name, expected, rdata);
      check_value({name, "_rresp"}, 32'd0, {30'd0, rresp});
      done = 1'b0;
      while (!done)
      begin
         take_random_bit(ready_bit);
         @(posedge clk);
         rready <= ready_bit;
         @(negedge clk);
         done = rvalid && rready;
      end
      @(posedge clk);
      rready <= 1'b0;
   endtask

   task automatic check_outputs(input logic [31:0] sel, input logic [31:0] expected,
                                input string name);
      logic [31:0] actual;
      @(negedge clk);
      case (sel)
         32'd0:   actual = {28'd0, flags};
         32'd1:   actual = {26'd0, move_index};
         32'd2:   actual = {23'd0, pos.white_to_move, pos.castle_mask, pos.ep_col};
         32'd3:   actual = {24'd0, pos.half_move};
         default: actual = pos.board[sel[2:0]*32 +: 32]; // Board row 0..7
      endcase
      check_value(name, expected, actual);
   endtask

   initial
   begin
      clk         = 1'b0;
      rst         = 1'b1;
      awaddr      = '0;
      awprot      = '0;
      awvalid     = 1'b0;
      wdata       = '0;
      wstrb       = 4'hF;
      wvalid      = 1'b0;
      bready      = 1'b0;
      araddr      = '0;
      arprot      = '0;
      arvalid     = 1'b0;
      rready      = 1'b0;
      misc_status = '0;
      lfsr        = 16'd41447;
      load_golden();
      cycle_limit = step_op.size() * 20 + 100;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      foreach (step_op[i])
      begin
         if (step_op[i] == "M")
         begin
            @(posedge clk);
            misc_status <= step_value[i];
         end
         else if (step_op[i] == "W")
            axi_write(step_addr[i], step_value[i], step_name[i]);
         else if (step_op[i] == "R")
            axi_read(step_addr[i], step_value[i], step_name[i]);
         else
            check_outputs(step_addr[i], step_value[i], step_name[i]);
      end
      @(posedge clk);
      $display("Regression passed");
      $finish;
   end

endmodule
